// ==== design/sb_config.svh ====
`ifndef SB_CONFIG_SVH
`define SB_CONFIG_SVH

// instruction window entries
`define SB_WINDOW_DEPTH 16

// architectural registers
`define SB_NUM_REGS 32

// occupancy at which new instructions are held off
`define SB_STALL_LEVEL 12

// multiplier cycles from start to done
`define SB_MUL_LATENCY 3

// data and pc width
`define SB_DATA_WD 32

`endif

// ==== design/sb_pkg.sv ====
`include "sb_config.svh"

package sb_pkg;

    // register format view
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // immediate format view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    // producer tag, also the unit id
    typedef logic [1:0] fu_tag_t;
    localparam fu_tag_t FU_NONE = 2'd0;
    localparam fu_tag_t FU_ALU  = 2'd1;
    localparam fu_tag_t FU_MUL  = 2'd2;

    typedef logic [3:0] fu_op_t;
    localparam fu_op_t OP_ADD = 4'd0;
    localparam fu_op_t OP_SUB = 4'd1;
    localparam fu_op_t OP_AND = 4'd2;
    localparam fu_op_t OP_OR  = 4'd3;
    localparam fu_op_t OP_SLT = 4'd4;
    localparam fu_op_t OP_LUI = 4'd5;
    localparam fu_op_t OP_MUL = 4'd6;

    typedef logic [$clog2(`SB_WINDOW_DEPTH)-1:0] win_idx_t;

    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OPC_ADDIU    = 6'h09;
    localparam logic [5:0] OPC_ORI      = 6'h0d;
    localparam logic [5:0] OPC_LUI      = 6'h0f;

    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_MUL  = 6'h02;

endpackage

// ==== design/decode_unit.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module decode_unit (
    input  sb_pkg::instr_t         inst,
    output sb_pkg::fu_tag_t        fu,
    output sb_pkg::fu_op_t         op,
    output logic [4:0]             src1,
    output logic [4:0]             src2,
    output logic [4:0]             dest,
    output logic                   use1,
    output logic                   use2,
    output logic                   use_imm,
    output logic [`SB_DATA_WD-1:0] imm
);
    import sb_pkg::*;

    always_comb begin
        // unknown encodings fall through as an alu add into r0
        fu      = FU_ALU;
        op      = OP_ADD;
        src1    = inst.r.rs;
        src2    = inst.r.rt;
        dest    = 5'd0;
        use1    = 1'b0;
        use2    = 1'b0;
        use_imm = 1'b0;
        imm     = {{(`SB_DATA_WD-16){inst.i.imm[15]}}, inst.i.imm};
        case (inst.r.opcode)
            OPC_SPECIAL: begin
                use1 = 1'b1;
                use2 = 1'b1;
                dest = inst.r.rd;
                case (inst.r.funct)
                    FN_ADD, FN_ADDU: op = OP_ADD;
                    FN_SUB, FN_SUBU: op = OP_SUB;
                    FN_AND:          op = OP_AND;
                    FN_OR:           op = OP_OR;
                    FN_SLT:          op = OP_SLT;
                    default: begin
                        use1 = 1'b0;
                        use2 = 1'b0;
                        dest = 5'd0;
                    end
                endcase
            end
            OPC_SPECIAL2: begin
                if (inst.r.funct == FN_MUL) begin
                    fu   = FU_MUL;
                    op   = OP_MUL;
                    use1 = 1'b1;
                    use2 = 1'b1;
                    dest = inst.r.rd;
                end
            end
            OPC_ADDIU: begin
                use1    = 1'b1;
                use_imm = 1'b1;
                dest    = inst.i.rt;
            end
            OPC_ORI, OPC_LUI: begin
                op      = (inst.i.opcode == OPC_LUI) ? OP_LUI : OP_OR;
                use1    = (inst.i.opcode == OPC_ORI);
                use_imm = 1'b1;
                dest    = inst.i.rt;
                // zero extended for logic ops and lui
                imm     = {{(`SB_DATA_WD-16){1'b0}}, inst.i.imm};
            end
            default: ;
        endcase
    end

endmodule

// ==== design/inst_window.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module inst_window (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   inst_valid,
    input  sb_pkg::instr_t         inst,
    input  logic [`SB_DATA_WD-1:0] pc,
    input  logic                   dispatch,
    input  logic                   alu_done,
    input  logic                   mul_done,
    input  logic [`SB_DATA_WD-1:0] alu_result,
    input  logic [`SB_DATA_WD-1:0] mul_result,
    input  sb_pkg::win_idx_t       alu_idx,
    input  sb_pkg::win_idx_t       mul_idx,
    output logic                   stallreq,
    output logic                   head_valid,
    output sb_pkg::fu_tag_t        head_fu,
    output sb_pkg::fu_op_t         head_op,
    output logic [4:0]             head_src1,
    output logic [4:0]             head_src2,
    output logic [4:0]             head_dest,
    output logic                   head_use1,
    output logic                   head_use2,
    output logic                   head_use_imm,
    output logic [`SB_DATA_WD-1:0] head_imm,
    output sb_pkg::win_idx_t       head_idx,
    output logic                   commit,
    output sb_pkg::fu_tag_t        commit_fu,
    output logic [4:0]             commit_dest,
    output logic [`SB_DATA_WD-1:0] commit_data,
    output logic [`SB_DATA_WD-1:0] commit_pc
);
    import sb_pkg::*;

    localparam int DEPTH  = `SB_WINDOW_DEPTH;
    localparam int OCC_WD = $clog2(DEPTH) + 1;

    fu_tag_t                d_fu;
    fu_op_t                 d_op;
    logic [4:0]             d_src1;
    logic [4:0]             d_src2;
    logic [4:0]             d_dest;
    logic                   d_use1;
    logic                   d_use2;
    logic                   d_use_imm;
    logic [`SB_DATA_WD-1:0] d_imm;

    // stage bits
    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] dispatched;
    logic [DEPTH-1:0] done;

    logic [`SB_DATA_WD-1:0] e_pc     [DEPTH];
    fu_tag_t                e_fu     [DEPTH];
    fu_op_t                 e_op     [DEPTH];
    logic [4:0]             e_src1   [DEPTH];
    logic [4:0]             e_src2   [DEPTH];
    logic [4:0]             e_dest   [DEPTH];
    logic                   e_use1   [DEPTH];
    logic                   e_use2   [DEPTH];
    logic                   e_use_imm[DEPTH];
    logic [`SB_DATA_WD-1:0] e_imm    [DEPTH];
    logic [`SB_DATA_WD-1:0] e_result [DEPTH];

    win_idx_t          wptr;
    win_idx_t          dptr;
    win_idx_t          rptr;
    logic [OCC_WD-1:0] count;
    logic [OCC_WD-1:0] count_next;
    logic              accept;

    decode_unit u_decode (
        .inst    (inst),
        .fu      (d_fu),
        .op      (d_op),
        .src1    (d_src1),
        .src2    (d_src2),
        .dest    (d_dest),
        .use1    (d_use1),
        .use2    (d_use2),
        .use_imm (d_use_imm),
        .imm     (d_imm)
    );

    assign accept = inst_valid && !stallreq;
    // oldest entry leaves once its result is back
    assign commit = valid[rptr] && done[rptr];

    always_comb begin
        count_next = count;
        if (accept && !commit) begin
            count_next = count + 1'b1;
        end else if (commit && !accept) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr       <= '0;
            dptr       <= '0;
            rptr       <= '0;
            count      <= '0;
            stallreq   <= 1'b0;
            valid      <= '0;
            dispatched <= '0;
            done       <= '0;
        end else begin
            count    <= count_next;
            stallreq <= (count_next >= OCC_WD'(`SB_STALL_LEVEL));
            if (accept) begin
                valid[wptr]      <= 1'b1;
                dispatched[wptr] <= 1'b0;
                done[wptr]       <= 1'b0;
                wptr             <= wptr + 1'b1;
            end
            if (dispatch) begin
                dispatched[dptr] <= 1'b1;
                dptr             <= dptr + 1'b1;
            end
            if (alu_done) begin
                done[alu_idx] <= 1'b1;
            end
            if (mul_done) begin
                done[mul_idx] <= 1'b1;
            end
            if (commit) begin
                valid[rptr] <= 1'b0;
                rptr        <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            e_pc[wptr]      <= pc;
            e_fu[wptr]      <= d_fu;
            e_op[wptr]      <= d_op;
            e_src1[wptr]    <= d_src1;
            e_src2[wptr]    <= d_src2;
            e_dest[wptr]    <= d_dest;
            e_use1[wptr]    <= d_use1;
            e_use2[wptr]    <= d_use2;
            e_use_imm[wptr] <= d_use_imm;
            e_imm[wptr]     <= d_imm;
        end
        if (alu_done) begin
            e_result[alu_idx] <= alu_result;
        end
        if (mul_done) begin
            e_result[mul_idx] <= mul_result;
        end
    end

    // next entry waiting for a unit
    assign head_valid   = valid[dptr] && !dispatched[dptr];
    assign head_fu      = e_fu[dptr];
    assign head_op      = e_op[dptr];
    assign head_src1    = e_src1[dptr];
    assign head_src2    = e_src2[dptr];
    assign head_dest    = e_dest[dptr];
    assign head_use1    = e_use1[dptr];
    assign head_use2    = e_use2[dptr];
    assign head_use_imm = e_use_imm[dptr];
    assign head_imm     = e_imm[dptr];
    assign head_idx     = dptr;

    assign commit_fu   = e_fu[rptr];
    assign commit_dest = e_dest[rptr];
    assign commit_data = e_result[rptr];
    assign commit_pc   = e_pc[rptr];

endmodule

// ==== design/fu_status.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module fu_status (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   head_valid,
    input  sb_pkg::fu_tag_t        head_fu,
    input  sb_pkg::fu_op_t         head_op,
    input  logic [4:0]             head_src1,
    input  logic [4:0]             head_src2,
    input  logic [4:0]             head_dest,
    input  logic                   head_use1,
    input  logic                   head_use2,
    input  logic                   head_use_imm,
    input  logic [`SB_DATA_WD-1:0] head_imm,
    input  sb_pkg::win_idx_t       head_idx,
    input  logic                   commit,
    input  sb_pkg::fu_tag_t        commit_fu,
    input  logic [4:0]             commit_dest,
    output logic                   dispatch,
    output logic                   alu_start,
    output logic                   mul_start,
    output sb_pkg::fu_op_t         alu_op,
    output logic [`SB_DATA_WD-1:0] alu_imm,
    output logic                   alu_use_imm,
    output sb_pkg::win_idx_t       alu_idx,
    output sb_pkg::win_idx_t       mul_idx,
    output logic [4:0]             raddr [4]
);
    import sb_pkg::*;

    // slot 0 is the alu, slot 1 the multiplier
    logic       busy    [2];
    logic       started [2];
    logic [4:0] src1    [2];
    logic [4:0] src2    [2];
    fu_tag_t    t1      [2];
    fu_tag_t    t2      [2];
    win_idx_t   idx     [2];
    logic       rdy     [2];
    fu_tag_t    reg_status [`SB_NUM_REGS];
    fu_tag_t    cap1;
    fu_tag_t    cap2;
    logic       hslot;
    logic       cslot;

    assign hslot = (head_fu == FU_MUL);
    assign cslot = (commit_fu == FU_MUL);

    // unit free and no older writer of the same destination
    assign dispatch = head_valid && !busy[hslot] && (reg_status[head_dest] == FU_NONE);

    // a producer committing right now no longer counts
    assign cap1 = (!head_use1 || (commit && reg_status[head_src1] == commit_fu)) ?
                  FU_NONE : reg_status[head_src1];
    assign cap2 = (!head_use2 || (commit && reg_status[head_src2] == commit_fu)) ?
                  FU_NONE : reg_status[head_src2];

    // tags freed this cycle count as ready, the regfile bypasses the value
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            rdy[k] = busy[k] && !started[k] &&
                     (t1[k] == FU_NONE || (commit && t1[k] == commit_fu)) &&
                     (t2[k] == FU_NONE || (commit && t2[k] == commit_fu));
        end
    end

    assign alu_start = rdy[0];
    assign mul_start = rdy[1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int k = 0; k < 2; k++) begin
                busy[k]    <= 1'b0;
                started[k] <= 1'b0;
                t1[k]      <= FU_NONE;
                t2[k]      <= FU_NONE;
            end
            for (int r = 0; r < `SB_NUM_REGS; r++) begin
                reg_status[r] <= FU_NONE;
            end
        end else begin
            if (alu_start) begin
                started[0] <= 1'b1;
            end
            if (mul_start) begin
                started[1] <= 1'b1;
            end
            if (commit) begin
                busy[cslot]              <= 1'b0;
                started[cslot]           <= 1'b0;
                reg_status[commit_dest] <= FU_NONE;
                for (int k = 0; k < 2; k++) begin
                    if (t1[k] == commit_fu) begin
                        t1[k] <= FU_NONE;
                    end
                    if (t2[k] == commit_fu) begin
                        t2[k] <= FU_NONE;
                    end
                end
            end
            // the dispatching slot is idle, so it never collides with the release
            if (dispatch) begin
                busy[hslot] <= 1'b1;
                t1[hslot]   <= cap1;
                t2[hslot]   <= cap2;
                if (head_dest != 5'd0) begin
                    reg_status[head_dest] <= head_fu;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            src1[hslot] <= head_use1 ? head_src1 : 5'd0;
            src2[hslot] <= head_use2 ? head_src2 : 5'd0;
            idx[hslot]  <= head_idx;
            if (!hslot) begin
                alu_op      <= head_op;
                alu_imm     <= head_imm;
                alu_use_imm <= head_use_imm;
            end
        end
    end

    assign raddr[0] = src1[0];
    assign raddr[1] = src2[0];
    assign raddr[2] = src1[1];
    assign raddr[3] = src2[1];
    assign alu_idx  = idx[0];
    assign mul_idx  = idx[1];

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   we,
    input  logic [4:0]             waddr,
    input  logic [`SB_DATA_WD-1:0] wdata,
    input  logic [4:0]             raddr [4],
    output logic [`SB_DATA_WD-1:0] rdata [4]
);

    logic [`SB_DATA_WD-1:0] regs [`SB_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int r = 0; r < `SB_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // write first, r0 reads zero
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr[p] == 5'd0) begin
                rdata[p] = '0;
            end else if (we && waddr == raddr[p]) begin
                rdata[p] = wdata;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module alu_unit (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  sb_pkg::fu_op_t         op,
    input  logic [`SB_DATA_WD-1:0] a,
    input  logic [`SB_DATA_WD-1:0] b,
    input  logic [`SB_DATA_WD-1:0] imm,
    input  logic                   use_imm,
    output logic                   done,
    output logic [`SB_DATA_WD-1:0] result
);
    import sb_pkg::*;

    logic [`SB_DATA_WD-1:0] opb;
    logic [`SB_DATA_WD-1:0] res;

    assign opb = use_imm ? imm : b;

    always_comb begin
        case (op)
            OP_SUB:  res = a - opb;
            OP_AND:  res = a & opb;
            OP_OR:   res = a | opb;
            OP_SLT:  res = {{(`SB_DATA_WD-1){1'b0}}, $signed(a) < $signed(opb)};
            OP_LUI:  res = opb << 16;
            default: res = a + opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= res;
        end
    end

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module mul_unit (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic [`SB_DATA_WD-1:0] a,
    input  logic [`SB_DATA_WD-1:0] b,
    output logic                   done,
    output logic [`SB_DATA_WD-1:0] result
);

    localparam int LAT = `SB_MUL_LATENCY;

    logic [LAT-1:0]         vld;
    logic [`SB_DATA_WD-1:0] stage [LAT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld <= '0;
        end else begin
            vld <= (vld << 1) | LAT'(start);
        end
    end

    // only the low word of the product is kept
    always_ff @(posedge clk) begin
        stage[0] <= a * b;
        for (int k = 1; k < LAT; k++) begin
            stage[k] <= stage[k-1];
        end
    end

    assign done   = vld[LAT-1];
    assign result = stage[LAT-1];

endmodule

// ==== design/scoreboard_core.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module scoreboard_core (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   inst_valid,
    input  logic [31:0]            inst,
    input  logic [`SB_DATA_WD-1:0] pc,
    output logic                   stallreq,
    output logic [`SB_DATA_WD-1:0] debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [4:0]             debug_wb_rf_wnum,
    output logic [`SB_DATA_WD-1:0] debug_wb_rf_wdata
);
    import sb_pkg::*;

    logic                   head_valid;
    fu_tag_t                head_fu;
    fu_op_t                 head_op;
    logic [4:0]             head_src1;
    logic [4:0]             head_src2;
    logic [4:0]             head_dest;
    logic                   head_use1;
    logic                   head_use2;
    logic                   head_use_imm;
    logic [`SB_DATA_WD-1:0] head_imm;
    win_idx_t               head_idx;
    logic                   dispatch;
    logic                   commit;
    fu_tag_t                commit_fu;
    logic [4:0]             commit_dest;
    logic [`SB_DATA_WD-1:0] commit_data;
    logic                   alu_start;
    logic                   mul_start;
    logic                   alu_done;
    logic                   mul_done;
    logic [`SB_DATA_WD-1:0] alu_result;
    logic [`SB_DATA_WD-1:0] mul_result;
    fu_op_t                 alu_op;
    logic [`SB_DATA_WD-1:0] alu_imm;
    logic                   alu_use_imm;
    win_idx_t               alu_idx;
    win_idx_t               mul_idx;
    logic [4:0]             rf_raddr [4];
    logic [`SB_DATA_WD-1:0] rf_rdata [4];

    inst_window u_window (
        .clk          (clk),
        .resetn       (resetn),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .dispatch     (dispatch),
        .alu_done     (alu_done),
        .mul_done     (mul_done),
        .alu_result   (alu_result),
        .mul_result   (mul_result),
        .alu_idx      (alu_idx),
        .mul_idx      (mul_idx),
        .stallreq     (stallreq),
        .head_valid   (head_valid),
        .head_fu      (head_fu),
        .head_op      (head_op),
        .head_src1    (head_src1),
        .head_src2    (head_src2),
        .head_dest    (head_dest),
        .head_use1    (head_use1),
        .head_use2    (head_use2),
        .head_use_imm (head_use_imm),
        .head_imm     (head_imm),
        .head_idx     (head_idx),
        .commit       (commit),
        .commit_fu    (commit_fu),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data),
        .commit_pc    (debug_wb_pc)
    );

    fu_status u_status (
        .clk          (clk),
        .resetn       (resetn),
        .head_valid   (head_valid),
        .head_fu      (head_fu),
        .head_op      (head_op),
        .head_src1    (head_src1),
        .head_src2    (head_src2),
        .head_dest    (head_dest),
        .head_use1    (head_use1),
        .head_use2    (head_use2),
        .head_use_imm (head_use_imm),
        .head_imm     (head_imm),
        .head_idx     (head_idx),
        .commit       (commit),
        .commit_fu    (commit_fu),
        .commit_dest  (commit_dest),
        .dispatch     (dispatch),
        .alu_start    (alu_start),
        .mul_start    (mul_start),
        .alu_op       (alu_op),
        .alu_imm      (alu_imm),
        .alu_use_imm  (alu_use_imm),
        .alu_idx      (alu_idx),
        .mul_idx      (mul_idx),
        .raddr        (rf_raddr)
    );

    // architectural state changes only at commit
    regfile u_regfile (
        .clk    (clk),
        .resetn (resetn),
        .we     (commit),
        .waddr  (commit_dest),
        .wdata  (commit_data),
        .raddr  (rf_raddr),
        .rdata  (rf_rdata)
    );

    alu_unit u_alu (
        .clk     (clk),
        .resetn  (resetn),
        .start   (alu_start),
        .op      (alu_op),
        .a       (rf_rdata[0]),
        .b       (rf_rdata[1]),
        .imm     (alu_imm),
        .use_imm (alu_use_imm),
        .done    (alu_done),
        .result  (alu_result)
    );

    mul_unit u_mul (
        .clk    (clk),
        .resetn (resetn),
        .start  (mul_start),
        .a      (rf_rdata[2]),
        .b      (rf_rdata[3]),
        .done   (mul_done),
        .result (mul_result)
    );

    assign debug_wb_rf_wen   = {4{commit}};
    assign debug_wb_rf_wnum  = commit_dest;
    assign debug_wb_rf_wdata = commit_data;

endmodule

// ==== tests/tb_scoreboard_core.sv ====
`timescale 1ns/100ps
`include "sb_config.svh"

module tb_scoreboard_core;
    import sb_pkg::*;

    localparam int MAX_INSTR = 64;
    localparam int STALL_TEST = 5;

    logic        clk = 1'b0;
    logic        resetn;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        stallreq;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // four words per trace line: pc, instruction, gap flag, test id
    logic [31:0] trace_mem [0:4*MAX_INSTR+3];
    logic [31:0] model_rf  [32];
    logic [31:0] exp_pc    [MAX_INSTR];
    logic [4:0]  exp_dest  [MAX_INSTR];
    logic [31:0] exp_data  [MAX_INSTR];

    int          n_instr;
    int          ncommit;
    int          n_accepted;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          seg_base;
    int          stall_by_test [16];
    logic        exp_stall;
    logic        loaded = 1'b0;
    logic [31:0] seed = 32'hcf3c_a1e8;

    scoreboard_core i_dut (
        .clk               (clk),
        .resetn            (resetn),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .pc                (pc),
        .stallreq          (stallreq),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "alu operations";
            2: return "multiplier dependency chain";
            3: return "in-order commit";
            4: return "waw to one register";
            5: return "stall and back-pressure";
            6: return "register 0";
            default: return "unnamed";
        endcase
    endfunction

    // in-order model, run once over the whole trace
    task automatic build_expected();
        instr_t      w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  d;
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
        end
        for (int k = 0; k < n_instr; k++) begin
            w   = trace_mem[4*k+1];
            a   = model_rf[w.r.rs];
            b   = model_rf[w.r.rt];
            d   = 5'd0;
            res = '0;
            case (w.r.opcode)
                OPC_SPECIAL: begin
                    d = w.r.rd;
                    case (w.r.funct)
                        FN_ADD, FN_ADDU: res = a + b;
                        FN_SUB, FN_SUBU: res = a - b;
                        FN_AND:          res = a & b;
                        FN_OR:           res = a | b;
                        FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         d = 5'd0;
                    endcase
                end
                OPC_SPECIAL2: begin
                    if (w.r.funct == FN_MUL) begin
                        d   = w.r.rd;
                        res = a * b;
                    end
                end
                OPC_ADDIU: begin
                    d   = w.i.rt;
                    res = a + {{16{w.i.imm[15]}}, w.i.imm};
                end
                OPC_ORI: begin
                    d   = w.i.rt;
                    res = a | {16'h0000, w.i.imm};
                end
                OPC_LUI: begin
                    d   = w.i.rt;
                    res = {w.i.imm, 16'h0000};
                end
                default: ;
            endcase
            exp_pc[k]   = trace_mem[4*k];
            exp_dest[k] = d;
            exp_data[k] = res;
            if (d != 5'd0) begin
                model_rf[d] = res;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        inst_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds the instruction until the edge that accepts it
    task automatic issue_instr(input logic [31:0] ipc, input logic [31:0] word, input int id);
        inst_valid = 1'b1;
        inst       = word;
        pc         = ipc;
        while (stallreq) begin
            stall_by_test[id]++;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        n_accepted++;
        inst_valid = 1'b0;
    endtask

    task automatic check_commit(input int k);
        if (debug_wb_rf_wen !== 4'hf) begin
            $display("MISMATCH debug_wb_rf_wen: got %h expected %h", debug_wb_rf_wen, 4'hf);
            errors++;
        end
        if (debug_wb_pc !== exp_pc[k]) begin
            $display("MISMATCH debug_wb_pc: got %h expected %h", debug_wb_pc, exp_pc[k]);
            errors++;
        end
        if (debug_wb_rf_wnum !== exp_dest[k]) begin
            $display("MISMATCH debug_wb_rf_wnum: got %h expected %h at pc %h",
                     debug_wb_rf_wnum, exp_dest[k], exp_pc[k]);
            errors++;
        end
        if (debug_wb_rf_wdata !== exp_data[k]) begin
            $display("MISMATCH debug_wb_rf_wdata: got %h expected %h at pc %h",
                     debug_wb_rf_wdata, exp_data[k], exp_pc[k]);
            errors++;
        end
    endtask

    task automatic report_test(input int k);
        int id;
        int seg_errs;
        id = trace_mem[4*k+3];
        if (id == STALL_TEST && stall_by_test[id] == 0) begin
            $display("ERROR: stall request never rose during the multiply burst");
            errors++;
        end
        seg_errs = errors - seg_base;
        seg_base = errors;
        tests_run++;
        if (seg_errs != 0) begin
            tests_failed++;
        end
        $display("test %0d (%s): %s, %0d errors, %0d stall cycles", id, test_name(id),
                 (seg_errs == 0) ? "pass" : "fail", seg_errs, stall_by_test[id]);
    endtask

    // commit outputs only move at the rising edge
    always @(negedge clk) begin
        if (resetn === 1'b1) begin
            // occupancy after the last edge sets the stall request
            exp_stall = ((n_accepted - ncommit) >= `SB_STALL_LEVEL);
            if (stallreq !== exp_stall) begin
                $display("MISMATCH stallreq: got %h expected %h", stallreq, exp_stall);
                errors++;
            end
        end
        if (resetn === 1'b1 && debug_wb_rf_wen !== 4'h0) begin
            if (ncommit >= n_instr) begin
                $display("ERROR: extra commit of pc %h after all %0d instructions committed",
                         debug_wb_pc, n_instr);
                errors++;
            end else begin
                check_commit(ncommit);
                if (ncommit == n_instr - 1 ||
                    trace_mem[4*ncommit+7] != trace_mem[4*ncommit+3]) begin
                    report_test(ncommit);
                end
            end
            ncommit++;
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = n_instr * (`SB_MUL_LATENCY + 6) + 100;
        repeat (limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, %0d of %0d instructions committed",
                 limit, ncommit, n_instr);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int gap;
        resetn     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        $readmemh("tests/sb_trace.txt", trace_mem);
        n_instr = 0;
        while (n_instr < MAX_INSTR && trace_mem[4*n_instr] !== 32'hffffffff &&
               ^trace_mem[4*n_instr] !== 1'bx) begin
            n_instr++;
        end
        if (n_instr == 0) begin
            $display("ERROR: trace file holds no instructions");
            errors++;
        end
        build_expected();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (int k = 0; k < n_instr; k++) begin
            if (trace_mem[4*k+2] != 0) begin
                seed = lcg_next(seed);
                gap  = seed[25:24];
                idle_cycles(gap);
            end
            issue_instr(trace_mem[4*k], trace_mem[4*k+1], trace_mem[4*k+3]);
        end
        wait (ncommit >= n_instr);
        // leave room for a stray commit to show up
        repeat (20) @(posedge clk);
        if (ncommit != n_instr) begin
            $display("ERROR: saw %0d commits for %0d instructions", ncommit, n_instr);
            errors++;
        end
        $display("summary: %0d tests, %0d failed, %0d commits, %0d errors",
                 tests_run, tests_failed, ncommit, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== scoreboard_core.f ====
+incdir+design
design/sb_pkg.sv
design/decode_unit.sv
design/inst_window.sv
design/fu_status.sv
design/regfile.sv
design/alu_unit.sv
design/mul_unit.sv
design/scoreboard_core.sv
tests/tb_scoreboard_core.sv

// ==== tests/sb_trace.txt ====
// pc       instruction  gap  test
// gap 1 allows a random idle of 0 to 3 cycles before the instruction
bfc00000 34011234 0 1
bfc00004 2402fff0 1 1
bfc00008 3c038000 0 1
bfc0000c 00222020 1 1
bfc00010 00222822 0 1
bfc00014 00223024 1 1
bfc00018 00233825 0 1
bfc0001c 0061402a 1 1
bfc00020 0022482a 0 1
bfc00024 242a0010 1 1
bfc00028 240b0003 1 2
bfc0002c 71616002 0 2
bfc00030 718b6802 1 2
bfc00034 01ac7021 0 2
bfc00038 71ce7802 1 2
bfc0003c 01ed8022 0 2
bfc00040 70228802 1 3
bfc00044 341200aa 0 3
bfc00048 24130077 0 3
bfc0004c 34140011 1 4
bfc00050 26940022 0 4
bfc00054 728ba002 0 4
bfc00058 34140055 0 4
bfc0005c 0280a821 0 4
bfc00060 716bb002 1 5
bfc00064 72cbb002 0 5
bfc00068 72cbb002 0 5
bfc0006c 72cbb002 0 5
bfc00070 72cbb002 0 5
bfc00074 72cbb002 0 5
bfc00078 72cbb002 0 5
bfc0007c 72cbb002 0 5
bfc00080 72cbb002 0 5
bfc00084 72cbb002 0 5
bfc00088 72cbb002 0 5
bfc0008c 72cbb002 0 5
bfc00090 72cbb002 0 5
bfc00094 72cbb002 0 5
bfc00098 72cbb002 0 5
bfc0009c 72cbb002 0 5
bfc000a0 24200055 1 6
bfc000a4 0000b821 0 6
bfc000a8 0001c025 1 6
bfc000ac 70210002 0 6
bfc000b0 000bc821 1 6
// end of trace
ffffffff 00000000 0 0
